// File: hdl/core_monitor_params.svh
// Core monitor build-time constants for event export and trace repacking
`ifndef CORE_MONITOR_PARAMS_SVH
`define CORE_MONITOR_PARAMS_SVH

// ----------------------------------------
// Cluster and event FIFO
// ----------------------------------------

// Number of monitored cores
`define CM_NUM_CORES 2

// Event FIFO holds 2**CM_LOG_DEPTH slots
`define CM_LOG_DEPTH 2

// Flops on the returned read pointer
`define CM_SYNC_STAGES 3

// ----------------------------------------
// Field widths
// ----------------------------------------

`define CM_PC_WIDTH 64

// Performance event record
`define CM_EID_WIDTH 8
`define CM_EINFO_WIDTH 32
`define CM_SID_WIDTH 4

// Branch type code from the core
`define CM_CTR_TYPE_WIDTH 4

`endif

// File: hdl/core_monitor_pkg.sv
// Core monitor types for performance events, branch traces and FIFO pointers
`include "core_monitor_params.svh"

package core_monitor_pkg;

  // ----------------------------------------
  // Performance events
  // ----------------------------------------

  // One event record per core per cycle, id zero means no event
  typedef struct packed {
    logic [`CM_EID_WIDTH-1:0]   e_id;
    logic [`CM_EINFO_WIDTH-1:0] e_info;
    logic [`CM_SID_WIDTH-1:0]   s_id;
  } pmu_event_t;

  // Gray coded FIFO pointer with one wrap bit above the slot index
  typedef logic [`CM_LOG_DEPTH:0] cdc_ptr_t;

  // ----------------------------------------
  // Branch traces
  // ----------------------------------------

  // Raw control flow record as a core emits it
  typedef struct packed {
    logic [`CM_PC_WIDTH-1:0]       src_pc;
    logic [`CM_PC_WIDTH-1:0]       dst_pc;
    logic                          src_valid;
    logic [`CM_CTR_TYPE_WIDTH-1:0] ctr_type;
    logic [1:0]                    priv_lvl;
    logic [31:0]                   instr;
  } core_trace_t;

  // Trace record split into 32-bit words for the trace consumer
  typedef struct packed {
    logic [1:0]  priv_lvl;
    logic [31:0] pc_src_h;
    logic [31:0] pc_src_l;
    logic [31:0] pc_dst_h;
    logic [31:0] pc_dst_l;
    // Transfer type, zero extended
    logic [31:0] metadata;
    logic [31:0] opcode;
    logic        pc_v;
  } snoop_trace_t;

endpackage

// File: hdl/event_cdc_src.sv
// Write side of a gray-pointer async FIFO exporting one core's nonzero events
`timescale 1ns/1ps
`include "core_monitor_params.svh"

module event_cdc_src
  import core_monitor_pkg::*;
#(
  parameter int LOG_DEPTH = `CM_LOG_DEPTH
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  pmu_event_t                    event_i,
  output pmu_event_t [2**LOG_DEPTH-1:0] async_data_o,
  output cdc_ptr_t                      async_wptr_o,
  input  cdc_ptr_t                      async_rptr_i
);

  localparam int depth       = 2 ** LOG_DEPTH;
  localparam int sync_stages = `CM_SYNC_STAGES;

  typedef logic [LOG_DEPTH:0] ptr_t;

  // Full when the two top gray bits differ and the rest agree
  localparam ptr_t full_mask = ptr_t'(2'b11) << (LOG_DEPTH - 1);

  function automatic ptr_t bin_to_gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // ----------------------------------------
  // Declarations
  // ----------------------------------------

  // Binary count and its registered gray image
  ptr_t                   wbin_q;
  ptr_t                   wgray_q;
  ptr_t                   wbin_next;

  // Read pointer from the far domain, oldest stage last
  ptr_t [sync_stages-1:0] rgray_sync_q;
  ptr_t                   rgray_sync;

  pmu_event_t [depth-1:0] data_q;
  logic [LOG_DEPTH-1:0]   waddr;
  logic                   full;
  logic                   push;

  // ----------------------------------------
  // Full detection
  // ----------------------------------------

  assign rgray_sync = rgray_sync_q[sync_stages-1];
  assign full       = (wgray_q == (rgray_sync ^ full_mask));

  // Source is never stalled, a push into a full FIFO is lost
  assign push = (|event_i.e_id) && !full;

  assign waddr     = wbin_q[LOG_DEPTH-1:0];
  assign wbin_next = wbin_q + ptr_t'(1);

  // Only the gray code crosses, so one bit moves per step
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rgray_sync_q <= '0;
    end else begin
      rgray_sync_q[0] <= ptr_t'(async_rptr_i);
      for (int s = 1; s < sync_stages; s++) begin
        rgray_sync_q[s] <= rgray_sync_q[s-1];
      end
    end
  end

  // ----------------------------------------
  // Write side
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wbin_q  <= '0;
      wgray_q <= '0;
    end else if (push) begin
      wbin_q  <= wbin_next;
      wgray_q <= bin_to_gray(wbin_next);
    end
  end

  // Slot and pointer update on the same edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_q <= '0;
    end else if (push) begin
      data_q[waddr] <= event_i;
    end
  end

  assign async_data_o = data_q;
  assign async_wptr_o = cdc_ptr_t'(wgray_q);

endmodule

// File: hdl/trace_select.sv
// Branch trace selector repacking one core's program counters into 32-bit words
`timescale 1ns/1ps
`include "core_monitor_params.svh"

module trace_select
  import core_monitor_pkg::*;
(
  input  core_trace_t [`CM_NUM_CORES-1:0] traces_i,
  input  logic                            core_select_i,
  output snoop_trace_t                    snoop_trace_o
);

  localparam int pc_w   = `CM_PC_WIDTH;
  localparam int word_w = 32;

  // ----------------------------------------
  // PC word split
  // ----------------------------------------

  // Upper word, top pc bit is replaced by zero
  function automatic logic [word_w-1:0] pc_high(input logic [pc_w-1:0] pc);
    return {1'b0, pc[pc_w-2:word_w]};
  endfunction

  // Lower word, bit 0 is always zero for aligned instructions
  function automatic logic [word_w-1:0] pc_low(input logic [pc_w-1:0] pc);
    return {pc[word_w-1:1], 1'b0};
  endfunction

  core_trace_t sel_trace;

  // Level select, no pipelining
  assign sel_trace = traces_i[core_select_i];

  // ----------------------------------------
  // Output record
  // ----------------------------------------

  assign snoop_trace_o.priv_lvl = sel_trace.priv_lvl;
  assign snoop_trace_o.pc_src_h = pc_high(sel_trace.src_pc);
  assign snoop_trace_o.pc_src_l = pc_low(sel_trace.src_pc);
  assign snoop_trace_o.pc_dst_h = pc_high(sel_trace.dst_pc);
  assign snoop_trace_o.pc_dst_l = pc_low(sel_trace.dst_pc);

  // Transfer type sits in the low bits
  assign snoop_trace_o.metadata = {
    {(word_w - `CM_CTR_TYPE_WIDTH){1'b0}},
    sel_trace.ctr_type
  };

  assign snoop_trace_o.opcode = sel_trace.instr;
  assign snoop_trace_o.pc_v   = sel_trace.src_valid;

endmodule

// File: hdl/core_monitor_top.sv
// Core monitor front end with per-core event FIFO sources and trace selection
`timescale 1ns/1ps
`include "core_monitor_params.svh"

module core_monitor_top
  import core_monitor_pkg::*;
(
  input  logic                                                    clk_i,
  input  logic                                                    reset_i,

  // Performance events, one record per core per cycle
  input  pmu_event_t [`CM_NUM_CORES-1:0]                          events_i,

  // Async FIFO write side toward the far domain
  output pmu_event_t [`CM_NUM_CORES-1:0][(2**`CM_LOG_DEPTH)-1:0] cdc_data_o,
  output cdc_ptr_t [`CM_NUM_CORES-1:0]                            cdc_wptr_o,
  input  cdc_ptr_t [`CM_NUM_CORES-1:0]                            cdc_rptr_i,

  // Branch traces
  input  core_trace_t [`CM_NUM_CORES-1:0]                         traces_i,
  input  logic                                                    core_select_i,
  output snoop_trace_t                                            snoop_trace_o
);

  // ----------------------------------------
  // Event export
  // ----------------------------------------

  // Independent FIFO per core, the far side reads each one separately
  for (genvar i = 0; i < `CM_NUM_CORES; i++) begin : gen_core
    event_cdc_src #(
      .LOG_DEPTH    ( `CM_LOG_DEPTH )
    ) i_event_src (
      .clk_i        ( clk_i         ),
      .reset_i      ( reset_i       ),
      .event_i      ( events_i[i]   ),
      .async_data_o ( cdc_data_o[i] ),
      .async_wptr_o ( cdc_wptr_o[i] ),
      .async_rptr_i ( cdc_rptr_i[i] )
    );
  end

  // ----------------------------------------
  // Trace selection
  // ----------------------------------------

  trace_select i_trace_select (
    .traces_i      ( traces_i      ),
    .core_select_i ( core_select_i ),
    .snoop_trace_o ( snoop_trace_o )
  );

endmodule

// File: verification/core_monitor_tb.sv
// Testbench for the core monitor, checking event FIFO export and trace repacking
`timescale 1ns/1ps
`include "core_monitor_params.svh"

module core_monitor_tb
  import core_monitor_pkg::*;
();

  localparam int num_cores = `CM_NUM_CORES;
  localparam int depth     = 2 ** `CM_LOG_DEPTH;
  localparam int ptr_range = 2 * depth;
  // Three sync stages plus one spare edge
  localparam int sync_wait = 4;

  localparam int op_push  = 0;
  localparam int op_read  = 1;
  localparam int op_trace = 2;

  typedef struct {
    string                    name;
    int                       op;
    int                       core;
    logic [`CM_EID_WIDTH-1:0] e_id;
    logic                     exp_accept;
  } step_t;

  logic                                  clk_i;
  logic                                  reset_i;
  pmu_event_t [num_cores-1:0]            events_i;
  pmu_event_t [num_cores-1:0][depth-1:0] cdc_data_o;
  cdc_ptr_t [num_cores-1:0]              cdc_wptr_o;
  cdc_ptr_t [num_cores-1:0]              cdc_rptr_i;
  core_trace_t [num_cores-1:0]           traces_i;
  logic                                  core_select_i;
  snoop_trace_t                          snoop_trace_o;

  step_t steps[$];

  // Reference model of each core's FIFO
  int         wr_count [num_cores];
  int         rd_count [num_cores];
  pmu_event_t slots    [num_cores][depth];

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  core_monitor_top dut0 (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .events_i      ( events_i      ),
    .cdc_data_o    ( cdc_data_o    ),
    .cdc_wptr_o    ( cdc_wptr_o    ),
    .cdc_rptr_i    ( cdc_rptr_i    ),
    .traces_i      ( traces_i      ),
    .core_select_i ( core_select_i ),
    .snoop_trace_o ( snoop_trace_o )
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic check_value(input string name, input logic [255:0] expected,
                             input logic [255:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      $display("Errors found");
      $fatal(1, "Value mismatch");
    end
  endtask

  function automatic cdc_ptr_t to_gray(input int count);
    logic [`CM_LOG_DEPTH:0] b;
    b = count[`CM_LOG_DEPTH:0];
    return b ^ (b >> 1);
  endfunction

  // Words as the 32-bit trace consumer expects them
  function automatic snoop_trace_t expected_trace(input core_trace_t t);
    snoop_trace_t e;
    e.priv_lvl = t.priv_lvl;
    e.pc_src_h = {1'b0, t.src_pc[62:32]};
    e.pc_src_l = {t.src_pc[31:1], 1'b0};
    e.pc_dst_h = {1'b0, t.dst_pc[62:32]};
    e.pc_dst_l = {t.dst_pc[31:1], 1'b0};
    e.metadata = 32'(t.ctr_type);
    e.opcode   = t.instr;
    e.pc_v     = t.src_valid;
    return e;
  endfunction

  // Both pcs get their dropped bits set
  function automatic core_trace_t random_trace();
    core_trace_t t;
    t.src_pc     = {$urandom, $urandom};
    t.src_pc[63] = 1'b1;
    t.src_pc[0]  = 1'b1;
    t.dst_pc     = {$urandom, $urandom};
    t.dst_pc[63] = 1'b1;
    t.dst_pc[0]  = 1'b1;
    t.src_valid  = 1'($urandom);
    t.ctr_type   = 4'($urandom);
    t.priv_lvl   = 2'($urandom);
    t.instr      = $urandom;
    return t;
  endfunction

  task automatic compare_fifo_state(input string name);
    for (int c = 0; c < num_cores; c++) begin
      check_value($sformatf("%s wptr core %0d", name, c),
                  256'(to_gray(wr_count[c])), 256'(cdc_wptr_o[c]));
      for (int k = 0; k < depth; k++) begin
        check_value($sformatf("%s slot %0d core %0d", name, k, c),
                    256'(slots[c][k]), 256'(cdc_data_o[c][k]));
      end
    end
  endtask

  task automatic watchdog(input int limit_ns);
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("Errors found");
    $fatal(1, "Watchdog expired");
  endtask

  // ----------------------------------------
  // Step handlers
  // ----------------------------------------

  task automatic apply_push(input step_t s);
    pmu_event_t ev;
    cdc_ptr_t   wptr_before;
    logic       accepted;
    logic       model_accept;
    int         used;
    ev.e_id      = s.e_id;
    ev.e_info    = $urandom;
    ev.s_id      = s.core[`CM_SID_WIDTH-1:0];
    used         = (wr_count[s.core] - rd_count[s.core] + ptr_range) % ptr_range;
    model_accept = (s.e_id != '0) && (used != depth);
    wptr_before  = cdc_wptr_o[s.core];
    events_i[s.core] = ev;
    @(posedge clk_i);
    @(negedge clk_i);
    events_i[s.core] = '0;
    accepted = (cdc_wptr_o[s.core] != wptr_before);
    check_value({s.name, " accept"}, 256'(s.exp_accept), 256'(accepted));
    if (model_accept) begin
      slots[s.core][wr_count[s.core] % depth] = ev;
      wr_count[s.core] = (wr_count[s.core] + 1) % ptr_range;
    end
    compare_fifo_state(s.name);
  endtask

  // Far side consumes one slot
  task automatic apply_read(input step_t s);
    logic was_full;
    was_full = ((wr_count[s.core] - rd_count[s.core] + ptr_range) % ptr_range) == depth;
    rd_count[s.core]   = (rd_count[s.core] + 1) % ptr_range;
    cdc_rptr_i[s.core] = to_gray(rd_count[s.core]);
    // Freed slot stays unusable until the pointer clears the synchronizer
    if (was_full) begin
      events_i[s.core].e_id = '1;
    end
    repeat (`CM_SYNC_STAGES) @(negedge clk_i);
    events_i[s.core] = '0;
    check_value({s.name, " early push"}, 256'(to_gray(wr_count[s.core])),
                256'(cdc_wptr_o[s.core]));
    repeat (sync_wait - `CM_SYNC_STAGES) @(negedge clk_i);
    compare_fifo_state(s.name);
  endtask

  task automatic apply_trace(input step_t s);
    core_trace_t  t [num_cores];
    snoop_trace_t e;
    for (int c = 0; c < num_cores; c++) begin
      t[c]        = random_trace();
      traces_i[c] = t[c];
    end
    core_select_i = s.core[0];
    @(posedge clk_i);
    e = expected_trace(t[s.core]);
    check_value({s.name, " priv_lvl"}, 256'(e.priv_lvl), 256'(snoop_trace_o.priv_lvl));
    check_value({s.name, " pc_src_h"}, 256'(e.pc_src_h), 256'(snoop_trace_o.pc_src_h));
    check_value({s.name, " pc_src_l"}, 256'(e.pc_src_l), 256'(snoop_trace_o.pc_src_l));
    check_value({s.name, " pc_dst_h"}, 256'(e.pc_dst_h), 256'(snoop_trace_o.pc_dst_h));
    check_value({s.name, " pc_dst_l"}, 256'(e.pc_dst_l), 256'(snoop_trace_o.pc_dst_l));
    check_value({s.name, " metadata"}, 256'(e.metadata), 256'(snoop_trace_o.metadata));
    check_value({s.name, " opcode"}, 256'(e.opcode), 256'(snoop_trace_o.opcode));
    check_value({s.name, " pc_v"}, 256'(e.pc_v), 256'(snoop_trace_o.pc_v));
    @(negedge clk_i);
  endtask

  // ----------------------------------------
  // Step table
  // ----------------------------------------

  task automatic add_step(input string name, input int op, input int core,
                          input logic [`CM_EID_WIDTH-1:0] e_id, input logic exp_accept);
    step_t s;
    s.name       = name;
    s.op         = op;
    s.core       = core;
    s.e_id       = e_id;
    s.exp_accept = exp_accept;
    steps.push_back(s);
  endtask

  task automatic build_table();
    add_step("c0_push0", op_push, 0, 8'h01, 1'b1);
    add_step("c1_push0", op_push, 1, 8'h21, 1'b1);
    add_step("c0_zero_id", op_push, 0, 8'h00, 1'b0);
    add_step("c0_push1", op_push, 0, 8'h02, 1'b1);
    add_step("c1_push1", op_push, 1, 8'h22, 1'b1);
    add_step("c0_push2", op_push, 0, 8'h03, 1'b1);
    // Fourth slot fills core 0
    add_step("c0_push3", op_push, 0, 8'h04, 1'b1);
    add_step("c0_drop0", op_push, 0, 8'h05, 1'b0);
    add_step("c0_drop1", op_push, 0, 8'h06, 1'b0);
    add_step("c1_zero_id", op_push, 1, 8'h00, 1'b0);
    add_step("c0_read0", op_read, 0, 8'h00, 1'b0);
    add_step("c0_push4", op_push, 0, 8'h07, 1'b1);
    add_step("c0_drop2", op_push, 0, 8'h08, 1'b0);
    add_step("c0_read1", op_read, 0, 8'h00, 1'b0);
    add_step("c0_read2", op_read, 0, 8'h00, 1'b0);
    add_step("c0_push5", op_push, 0, 8'h09, 1'b1);
    add_step("c0_push6", op_push, 0, 8'h0a, 1'b1);
    add_step("c0_drop3", op_push, 0, 8'h0b, 1'b0);
    add_step("c0_read3", op_read, 0, 8'h00, 1'b0);
    add_step("c0_read4", op_read, 0, 8'h00, 1'b0);
    add_step("c0_read5", op_read, 0, 8'h00, 1'b0);
    add_step("c0_read6", op_read, 0, 8'h00, 1'b0);
    // Write pointer wraps past all eight gray codes
    add_step("c0_push7", op_push, 0, 8'h0c, 1'b1);
    add_step("c0_push8", op_push, 0, 8'h0d, 1'b1);
    add_step("c1_push2", op_push, 1, 8'h23, 1'b1);
    add_step("c1_push3", op_push, 1, 8'h24, 1'b1);
    add_step("c1_drop0", op_push, 1, 8'h25, 1'b0);
    add_step("trace_c0_a", op_trace, 0, 8'h00, 1'b0);
    add_step("trace_c1_a", op_trace, 1, 8'h00, 1'b0);
    add_step("trace_c0_b", op_trace, 0, 8'h00, 1'b0);
    add_step("trace_c1_b", op_trace, 1, 8'h00, 1'b0);
    add_step("trace_c0_c", op_trace, 0, 8'h00, 1'b0);
    add_step("trace_c1_c", op_trace, 1, 8'h00, 1'b0);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    int limit_ns;
    void'($urandom(11988));
    reset_i       = 1'b1;
    events_i      = '0;
    cdc_rptr_i    = '0;
    traces_i      = '0;
    core_select_i = 1'b0;
    for (int c = 0; c < num_cores; c++) begin
      wr_count[c] = 0;
      rd_count[c] = 0;
      for (int k = 0; k < depth; k++) begin
        slots[c][k] = '0;
      end
    end
    build_table();
    limit_ns = (steps.size() * 10 + 100) * 10;
    fork
      watchdog(limit_ns);
    join_none
    repeat (2) @(negedge clk_i);
    reset_i = 1'b0;
    compare_fifo_state("after_reset");
    foreach (steps[i]) begin
      case (steps[i].op)
        op_push: apply_push(steps[i]);
        op_read: apply_read(steps[i]);
        default: apply_trace(steps[i]);
      endcase
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: flist.f
+incdir+hdl
hdl/core_monitor_pkg.sv
hdl/event_cdc_src.sv
hdl/trace_select.sv
hdl/core_monitor_top.sv
verification/core_monitor_tb.sv

// File: Bender.yml
package:
  name: core_monitor

export_include_dirs:
  - hdl

sources:
  # RTL in compile order
  - include_dirs:
      - hdl
    files:
      - hdl/core_monitor_pkg.sv
      - hdl/event_cdc_src.sv
      - hdl/trace_select.sv
      - hdl/core_monitor_top.sv

  # Testbench
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/core_monitor_tb.sv
